//--- verification/reg_xbar_tests.txt
# W m1_wr m1_addr m1_data m2_wr m2_addr m2_data
# I idle_cycles / C t0_reg0..2 t1_reg0..2 m1_err_count m2_err_count
# Reset values
I 6
C 00000000 00000000 00000000 00000000 00000000 00000000 0 0
# Single writes
W 1 00000000 a0000000 0 00000000 00000000
I 7
C a0000000 00000000 00000000 00000000 00000000 00000000 0 0
W 0 00000000 00000000 1 20000008 b1000002
I 7
C a0000000 00000000 00000000 00000000 00000000 b1000002 0 0
# Each initiator to each target and index
W 1 00000004 a0000001 1 20000000 b1000000
I 1
W 1 00000008 a0000002 1 20000004 b1000001
I 1
W 1 20000000 a1000000 1 00000000 b0000000
I 1
W 1 20000004 a1000001 1 00000004 b0000001
I 1
W 1 20000008 a1000002 1 00000008 b0000002
I 8
C b0000000 b0000001 b0000002 a1000000 a1000001 a1000002 0 0
# Same cycle, same register and then different registers
W 1 00000004 c0000001 1 00000004 d0000001
I 8
C b0000000 d0000001 b0000002 a1000000 a1000001 a1000002 0 0
W 1 20000000 c1000000 1 20000008 d1000002
I 8
C b0000000 d0000001 b0000002 c1000000 a1000001 d1000002 0 0
# Decode errors
W 1 10000000 eeee0001 0 00000000 00000000
I 1
W 0 00000000 00000000 1 0000000c eeee0002
I 1
W 1 20000010 eeee0003 1 00000001 eeee0004
I 1
W 1 f0000004 eeee0005 0 00000000 00000000
W 0 00000000 00000000 1 00100008 eeee0006
I 8
C b0000000 d0000001 b0000002 c1000000 a1000001 d1000002 3 3
# Alternating traffic into target 0
W 1 00000000 50000000 0 00000000 00000000
W 0 00000000 00000000 1 00000004 60000001
W 1 00000008 50000002 0 00000000 00000000
W 0 00000000 00000000 1 00000000 60000000
W 1 00000004 50000001 0 00000000 00000000
W 0 00000000 00000000 1 00000008 60000002
I 8
C 60000000 50000001 60000002 c1000000 a1000001 d1000002 3 3
# Paired traffic into target 1
W 1 20000000 70000000 1 20000004 80000001
I 1
W 1 20000008 70000002 1 20000000 80000000
I 1
W 1 20000004 70000001 1 20000008 80000002
I 8
C 60000000 50000001 60000002 80000000 70000001 80000002 3 3

//--- tb.f
rtl/xbar_pkg.sv
rtl/addr_decoder.sv
rtl/write_queue.sv
rtl/reg_target.sv
rtl/reg_xbar_top.sv
verification/reg_xbar_sva.sv
verification/reg_xbar_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= reg_xbar_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

PASS_TEXT = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/reg_xbar_tb.sv
`timescale 1ns/10ps

module reg_xbar_tb
    import xbar_pkg::*;
();

    localparam int          CLK_PERIOD      = 40;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 5;
    localparam int          CYCLES_PER_LINE = 60;
    localparam int          MARGIN_CYCLES   = 400;
    localparam int          IDLE_GAP        = 8;
    localparam int          N_RANDOM        = 20;
    localparam logic [15:0] LFSR_SEED       = 16'd36884;
    localparam string       TEST_FILE       = "verification/reg_xbar_tests.txt";

    logic               clock;
    logic               rst_n;
    logic               m1_wr;
    addr_t              m1_addr;
    data_t              m1_data;
    logic               m2_wr;
    addr_t              m2_addr;
    data_t              m2_data;
    data_t [N_REGS-1:0] t0_regs;
    data_t [N_REGS-1:0] t1_regs;
    logic               m1_err;
    logic               m2_err;
    logic               t0_overflow;
    logic               t1_overflow;

    // Shadow model of both register banks
    data_t model_regs [2][N_REGS];
    int    model_err1;
    int    model_err2;

    // Error pulses seen on the DUT ports
    int dut_err1;
    int dut_err2;

    string       test_lines [$];
    bit          lines_loaded;
    logic [15:0] lfsr_state;

    reg_xbar_top reg_xbar_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .m1_wr       (m1_wr),
        .m1_addr     (m1_addr),
        .m1_data     (m1_data),
        .m2_wr       (m2_wr),
        .m2_addr     (m2_addr),
        .m2_data     (m2_data),
        .t0_regs     (t0_regs),
        .t1_regs     (t1_regs),
        .m1_err      (m1_err),
        .m2_err      (m2_err),
        .t0_overflow (t0_overflow),
        .t1_overflow (t1_overflow)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // Taps for x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic halt_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            halt_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            halt_with_failure($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            halt_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Address map rules applied to one initiator's strobe
    task automatic model_write(input int port, input logic wr, input addr_t addr,
                               input data_t data);
        int   tgt;
        int   idx;
        logic bad;
        if (wr) begin
            tgt = -1;
            if (addr[31:28] == TGT_LOW_BASE) begin
                tgt = 0;
            end else if (addr[31:28] == TGT_HIGH_BASE) begin
                tgt = 1;
            end
            idx = int'(addr[3:2]);
            bad = (tgt < 0) || (idx >= N_REGS) || (addr[27:4] != '0) || (addr[1:0] != '0);
            if (!bad) begin
                model_regs[tgt][idx] = data;
            end else if (port == 1) begin
                model_err1++;
            end else begin
                model_err2++;
            end
        end
    endtask

    // Initiator 1 is applied first, so initiator 2 wins a shared register
    task automatic drive_cycle(input logic w1, input addr_t a1, input data_t d1,
                               input logic w2, input addr_t a2, input data_t d2);
        @(posedge clock);
        #DRIVE_DELAY;
        m1_wr   = w1;
        m1_addr = a1;
        m1_data = d1;
        m2_wr   = w2;
        m2_addr = a2;
        m2_data = d2;
        model_write(1, w1, a1, d1);
        model_write(2, w2, a2, d2);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            drive_cycle(1'b0, '0, '0, 1'b0, '0, '0);
        end
    endtask

    function automatic data_t dut_word(input int t, input int i);
        if (t == 0) begin
            return t0_regs[i];
        end
        return t1_regs[i];
    endfunction

    task automatic check_expected(input string line);
        data_t v [2*N_REGS];
        int    e1;
        int    e2;
        int    n;
        n = $sscanf(line, "C %h %h %h %h %h %h %d %d", v[0], v[1], v[2], v[3], v[4], v[5],
                    e1, e2);
        if (n != 8) begin
            halt_with_failure($sformatf("Malformed check line: %s", line));
        end else begin
            // Shadow model against the file first
            for (int t = 0; t < 2; t++) begin
                for (int i = 0; i < N_REGS; i++) begin
                    check_data($sformatf("model t%0d_regs[%0d]", t, i), model_regs[t][i],
                               v[t*N_REGS+i]);
                end
            end
            check_count("model m1_err count", model_err1, e1);
            check_count("model m2_err count", model_err2, e2);
            for (int t = 0; t < 2; t++) begin
                for (int i = 0; i < N_REGS; i++) begin
                    check_data($sformatf("t%0d_regs[%0d]", t, i), dut_word(t, i),
                               v[t*N_REGS+i]);
                end
            end
            check_count("m1_err count", dut_err1, e1);
            check_count("m2_err count", dut_err2, e2);
        end
    endtask

    task automatic check_dut_vs_model();
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < N_REGS; i++) begin
                check_data($sformatf("t%0d_regs[%0d]", t, i), dut_word(t, i),
                           model_regs[t][i]);
            end
        end
        check_count("m1_err count", dut_err1, model_err1);
        check_count("m2_err count", dut_err2, model_err2);
    endtask

    task automatic load_tests();
        int    fd;
        int    status;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            halt_with_failure({"Could not open the test file ", TEST_FILE});
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (status > 1 && line.getc(0) != "#") begin
                    test_lines.push_back(line);
                end
            end
            $fclose(fd);
            lines_loaded = 1'b1;
        end
    endtask

    task automatic run_tests();
        int    w1;
        int    w2;
        addr_t a1;
        addr_t a2;
        data_t d1;
        data_t d2;
        int    n;
        int    idle;
        byte   kind;
        foreach (test_lines[k]) begin
            kind = test_lines[k].getc(0);
            case (kind)
                "W": begin
                    n = $sscanf(test_lines[k], "W %d %h %h %d %h %h", w1, a1, d1, w2, a2, d2);
                    if (n != 6) begin
                        halt_with_failure($sformatf("Malformed write line: %s", test_lines[k]));
                    end else begin
                        drive_cycle(w1 != 0, a1, d1, w2 != 0, a2, d2);
                    end
                end
                "I": begin
                    n = $sscanf(test_lines[k], "I %d", idle);
                    if (n != 1) begin
                        halt_with_failure($sformatf("Malformed idle line: %s", test_lines[k]));
                    end else begin
                        idle_cycles(idle);
                    end
                end
                "C": check_expected(test_lines[k]);
                default: halt_with_failure($sformatf("Unknown test line: %s", test_lines[k]));
            endcase
        end
    endtask

    // Initiators take turns so each strobes every other cycle
    task automatic run_random_phase();
        logic [31:0] tgt_bit;
        logic [31:0] idx_bits;
        logic [31:0] data_bits;
        addr_t       addr;
        for (int k = 0; k < N_RANDOM; k++) begin
            draw_bits(1, tgt_bit);
            draw_bits(2, idx_bits);
            draw_bits(32, data_bits);
            addr = {tgt_bit[0] ? TGT_HIGH_BASE : TGT_LOW_BASE, 24'h000000, idx_bits[1:0], 2'b00};
            if (k % 2 == 0) begin
                drive_cycle(1'b1, addr, data_bits, 1'b0, '0, '0);
            end else begin
                drive_cycle(1'b0, '0, '0, 1'b1, addr, data_bits);
            end
        end
        idle_cycles(IDLE_GAP);
        check_dut_vs_model();
    endtask

    always @(negedge clock) begin
        if (rst_n) begin
            if (m1_err) begin
                dut_err1++;
            end
            if (m2_err) begin
                dut_err2++;
            end
            check_flag("t0_overflow", t0_overflow, 1'b0);
            check_flag("t1_overflow", t1_overflow, 1'b0);
        end
    end

    // Watchdog sized from the number of test lines
    initial begin
        wait (lines_loaded);
        #(longint'(test_lines.size() * CYCLES_PER_LINE + MARGIN_CYCLES) * CLK_PERIOD);
        halt_with_failure("Watchdog expired before the tests finished");
    end

    initial begin
        rst_n        = 1'b0;
        m1_wr        = 1'b0;
        m1_addr      = '0;
        m1_data      = '0;
        m2_wr        = 1'b0;
        m2_addr      = '0;
        m2_data      = '0;
        model_err1   = 0;
        model_err2   = 0;
        dut_err1     = 0;
        dut_err2     = 0;
        lines_loaded = 1'b0;
        lfsr_state   = LFSR_SEED;
        foreach (model_regs[t, i]) begin
            model_regs[t][i] = '0;
        end
        load_tests();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        run_tests();
        run_random_phase();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verification/reg_xbar_sva.sv
`timescale 1ns/10ps

module reg_xbar_sva
    import xbar_pkg::*;
(
    input logic                   clock,
    input logic                   rst_n,
    input logic [QUEUE_CNT_W-1:0] count,
    input logic [QUEUE_PTR_W-1:0] wr_ptr,
    input logic [QUEUE_PTR_W-1:0] rd_ptr,
    input logic                   q_wr,
    input logic                   overflow
);

    // Occupancy stays within the storage and matches the pointer distance
    count_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        (count <= QUEUE_CNT_W'(QUEUE_DEPTH))
            && (QUEUE_PTR_W'(count) == QUEUE_PTR_W'(wr_ptr - rd_ptr))
    ) else $error("write queue occupancy out of step with its pointers");

    // Head strobe only while the pointers show stored entries
    pop_needs_entry: assert property (
        @(posedge clock) disable iff (!rst_n)
        q_wr |-> ((wr_ptr != rd_ptr) || (count == QUEUE_CNT_W'(QUEUE_DEPTH)))
    ) else $error("write queue popped while empty");

    // Traffic stays under one arrival per cycle per target
    no_overflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        !overflow
    ) else $error("write queue dropped a write");

endmodule

bind write_queue reg_xbar_sva queue_sva_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .count    (count),
    .wr_ptr   (wr_ptr),
    .rd_ptr   (rd_ptr),
    .q_wr     (q_wr),
    .overflow (overflow)
);

//--- rtl/reg_xbar_top.sv
`timescale 1ns/10ps

module reg_xbar_top
    import xbar_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               m1_wr,
    input  addr_t              m1_addr,
    input  data_t              m1_data,
    input  logic               m2_wr,
    input  addr_t              m2_addr,
    input  data_t              m2_data,
    output data_t [N_REGS-1:0] t0_regs,
    output data_t [N_REGS-1:0] t1_regs,
    output logic               m1_err,
    output logic               m2_err,
    output logic               t0_overflow,
    output logic               t1_overflow
);

    // Decoded writes from each initiator
    logic     d1_wr;
    tgt_sel_t d1_tgt;
    reg_idx_t d1_idx;
    data_t    d1_data;
    logic     d2_wr;
    tgt_sel_t d2_tgt;
    reg_idx_t d2_idx;
    data_t    d2_data;

    // Queue heads toward the targets
    logic     q0_wr;
    reg_idx_t q0_idx;
    data_t    q0_data;
    logic     q1_wr;
    reg_idx_t q1_idx;
    data_t    q1_data;

    addr_decoder dec_m1 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (m1_wr),
        .addr     (m1_addr),
        .data     (m1_data),
        .dec_wr   (d1_wr),
        .dec_tgt  (d1_tgt),
        .dec_idx  (d1_idx),
        .dec_data (d1_data),
        .err      (m1_err)
    );

    addr_decoder dec_m2 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr       (m2_wr),
        .addr     (m2_addr),
        .data     (m2_data),
        .dec_wr   (d2_wr),
        .dec_tgt  (d2_tgt),
        .dec_idx  (d2_idx),
        .dec_data (d2_data),
        .err      (m2_err)
    );

    // Initiator 1 on port a so it is queued first
    write_queue queue_t0 (
        .clock     (clock),
        .rst_n     (rst_n),
        .high_side (1'b0),
        .a_wr      (d1_wr),
        .a_tgt     (d1_tgt),
        .a_idx     (d1_idx),
        .a_data    (d1_data),
        .b_wr      (d2_wr),
        .b_tgt     (d2_tgt),
        .b_idx     (d2_idx),
        .b_data    (d2_data),
        .q_wr      (q0_wr),
        .q_idx     (q0_idx),
        .q_data    (q0_data),
        .overflow  (t0_overflow)
    );

    write_queue queue_t1 (
        .clock     (clock),
        .rst_n     (rst_n),
        .high_side (1'b1),
        .a_wr      (d1_wr),
        .a_tgt     (d1_tgt),
        .a_idx     (d1_idx),
        .a_data    (d1_data),
        .b_wr      (d2_wr),
        .b_tgt     (d2_tgt),
        .b_idx     (d2_idx),
        .b_data    (d2_data),
        .q_wr      (q1_wr),
        .q_idx     (q1_idx),
        .q_data    (q1_data),
        .overflow  (t1_overflow)
    );

    reg_target target_t0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .q_wr   (q0_wr),
        .q_idx  (q0_idx),
        .q_data (q0_data),
        .regs   (t0_regs)
    );

    reg_target target_t1 (
        .clock  (clock),
        .rst_n  (rst_n),
        .q_wr   (q1_wr),
        .q_idx  (q1_idx),
        .q_data (q1_data),
        .regs   (t1_regs)
    );

endmodule

//--- rtl/reg_target.sv
`timescale 1ns/10ps

module reg_target
    import xbar_pkg::*;
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 q_wr,
    input  reg_idx_t             q_idx,
    input  data_t                q_data,
    output data_t [N_REGS-1:0]   regs
);

    // One write enable per word
    logic [N_REGS-1:0] word_we;

    always_comb begin
        for (int i = 0; i < N_REGS; i++) begin
            word_we[i] = q_wr && (q_idx == reg_idx_t'(i));
        end
    end

    // Register bank drives the output levels directly
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < N_REGS; i++) begin
                if (word_we[i]) begin
                    regs[i] <= q_data;
                end
            end
        end
    end

endmodule

//--- rtl/write_queue.sv
`timescale 1ns/10ps

module write_queue
    import xbar_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     high_side,
    input  logic     a_wr,
    input  tgt_sel_t a_tgt,
    input  reg_idx_t a_idx,
    input  data_t    a_data,
    input  logic     b_wr,
    input  tgt_sel_t b_tgt,
    input  reg_idx_t b_idx,
    input  data_t    b_data,
    output logic     q_wr,
    output reg_idx_t q_idx,
    output data_t    q_data,
    output logic     overflow
);

    reg_idx_t idx_mem  [QUEUE_DEPTH];
    data_t    data_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] b_slot;
    logic [QUEUE_CNT_W-1:0] count;
    logic [QUEUE_CNT_W-1:0] space;

    tgt_sel_t own_tgt;
    logic     match_a;
    logic     match_b;
    logic     push_a;
    logic     push_b;
    logic     pop;

    assign own_tgt = high_side ? TGT_HIGH : TGT_LOW;

    assign match_a = a_wr && (a_tgt == own_tgt);
    assign match_b = b_wr && (b_tgt == own_tgt);

    // Head drains every cycle the queue holds something
    assign pop    = (count != '0);
    assign q_wr   = pop;
    assign q_idx  = idx_mem[rd_ptr];
    assign q_data = data_mem[rd_ptr];

    // A pop frees its slot in the same cycle
    assign space = QUEUE_CNT_W'(QUEUE_DEPTH) - count + QUEUE_CNT_W'(pop);

    // Port a claims the first free slot, port b the next one
    assign push_a = match_a && (space != '0);
    assign push_b = match_b && (space > QUEUE_CNT_W'(push_a));

    assign overflow = (match_a && !push_a) || (match_b && !push_b);

    // b lands right behind a when both push together
    assign b_slot = wr_ptr + QUEUE_PTR_W'(push_a);

    always_ff @(posedge clock) begin
        if (push_a) begin
            idx_mem[wr_ptr]  <= a_idx;
            data_mem[wr_ptr] <= a_data;
        end
        if (push_b) begin
            idx_mem[b_slot]  <= b_idx;
            data_mem[b_slot] <= b_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + QUEUE_PTR_W'(push_a) + QUEUE_PTR_W'(push_b);
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + QUEUE_CNT_W'(push_a) + QUEUE_CNT_W'(push_b)
                     - QUEUE_CNT_W'(pop);
        end
    end

endmodule

//--- rtl/addr_decoder.sv
`timescale 1ns/10ps

module addr_decoder
    import xbar_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     wr,
    input  addr_t    addr,
    input  data_t    data,
    output logic     dec_wr,
    output tgt_sel_t dec_tgt,
    output reg_idx_t dec_idx,
    output data_t    dec_data,
    output logic     err
);

    tgt_sel_t addr_tgt;
    reg_idx_t addr_idx;
    logic     addr_bad;

    // Target from the top nibble
    always_comb begin
        if (addr[31:28] == TGT_LOW_BASE) begin
            addr_tgt = TGT_LOW;
        end else if (addr[31:28] == TGT_HIGH_BASE) begin
            addr_tgt = TGT_HIGH;
        end else begin
            addr_tgt = TGT_NONE;
        end
    end

    assign addr_idx = addr[3:2];

    // Unmapped nibble, unused register slot or stray address bits
    always_comb begin
        addr_bad = 1'b0;
        if (addr_tgt == TGT_NONE) begin
            addr_bad = 1'b1;
        end
        if (int'(addr_idx) >= N_REGS) begin
            addr_bad = 1'b1;
        end
        if (addr[27:4] != '0 || addr[1:0] != '0) begin
            addr_bad = 1'b1;
        end
    end

    // Strobe and error pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_wr <= 1'b0;
            err    <= 1'b0;
        end else begin
            dec_wr <= wr && !addr_bad;
            err    <= wr && addr_bad;
        end
    end

    // Payload follows the strobe in the same stage
    always_ff @(posedge clock) begin
        if (wr) begin
            dec_tgt  <= addr_tgt;
            dec_idx  <= addr_idx;
            dec_data <= data;
        end
    end

endmodule

//--- rtl/xbar_pkg.sv
package xbar_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int REG_IDX_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Word registers per target
    localparam int N_REGS = 3;

    // Target select nibble in addr[31:28]
    localparam logic [3:0] TGT_LOW_BASE = 4'h0;
    localparam logic [3:0] TGT_HIGH_BASE = 4'h2;

    // Write queue geometry
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;
    // One extra bit so a full queue is distinguishable from an empty one
    localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;

    // Routing result of an address decoder
    typedef enum logic [1:0] {
        TGT_LOW,
        TGT_HIGH,
        TGT_NONE
    } tgt_sel_t;

endpackage
